//--- testbench/cache_stim.txt
# op (R or W), byte address, write data, expected read data, expected miss (1 or 0)
# a line "test <name>" opens a new group, expected read data is not checked on writes
test cold_read
R 00000004 00000000 00000000 1
R 00000004 00000000 00000000 0
test write_read
W 00000008 deadbeef 00000000 1
R 00000008 00000000 deadbeef 0
W 00000008 12345678 00000000 0
R 00000008 00000000 12345678 0
test two_tags_resident
W 0000000c a1a1a1a1 00000000 1
W 0000080c b2b2b2b2 00000000 1
R 0000000c 00000000 a1a1a1a1 0
R 0000080c 00000000 b2b2b2b2 0
R 0000000c 00000000 a1a1a1a1 0
R 0000080c 00000000 b2b2b2b2 0
test lru_evict_writeback
W 00000010 11111111 00000000 1
W 00000810 22222222 00000000 1
R 00000010 00000000 11111111 0
W 00001010 33333333 00000000 1
R 00000010 00000000 11111111 0
R 00000810 00000000 22222222 1
R 00001010 00000000 33333333 1
R 00000010 00000000 11111111 1
test write_miss_allocate
W 00000814 cafef00d 00000000 1
R 00000814 00000000 cafef00d 0
W 00000014 0badc0de 00000000 1
R 00000014 00000000 0badc0de 0
R 00000814 00000000 cafef00d 0

//--- vlog.f
+incdir+hw
hw/cache_pkg.sv
hw/set_if.sv
hw/mem_if.sv
hw/cache_set_array.sv
hw/backing_ram.sv
hw/two_way_cache_controller.sv
hw/cache_sequencer.sv
hw/two_way_cache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_two_way_cache.sv

//--- Bender.yml
package:
  name: two_way_cache

sources:
  - include_dirs:
      - hw
    files:
      - hw/cache_pkg.sv
      - hw/set_if.sv
      - hw/mem_if.sv
      - hw/cache_set_array.sv
      - hw/backing_ram.sv
      - hw/two_way_cache_controller.sv
      - hw/cache_sequencer.sv
      - hw/two_way_cache_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_two_way_cache.sv

//--- testbench/tb_two_way_cache.sv
`timescale 1ns/100ps

module tb_two_way_cache;
    import cache_pkg::*;

    localparam int    N_RANDOM  = 300;
    localparam int    ACCESS_NS = 200;    // budget per access
    localparam int    MARGIN_NS = 2000;
    localparam string STIM_FILE = "testbench/cache_stim.txt";

    logic      clk;
    logic      rst_n;
    logic      req;
    logic      we;
    ram_addr_t addr;
    data_t     wd;
    logic      ack;
    data_t     rd;
    logic      miss;

    // directed stimulus where a 'T' entry opens a new test group
    byte         op_q[$];
    string       name_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] wd_q[$];
    logic [31:0] exp_rd_q[$];
    bit          exp_miss_q[$];

    // reference model
    logic [20:0] model_tag [512][2];
    bit          model_valid [512][2];
    bit          model_lru [512];      // way to replace next
    logic [31:0] model_mem [int unsigned];

    logic [31:0] lcg_state = 32'd82433;
    int          access_total = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name;
    int          errors_at_start;
    int          checks_at_start;
    bit          test_open = 1'b0;
    logic [31:0] got_rd;
    logic        got_miss;
    logic [31:0] exp_rd;
    bit          exp_miss;
    logic [31:0] r;
    bit          r_we;
    logic [31:0] r_addr;
    logic [31:0] r_wd;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    two_way_cache_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wd    (wd),
        .ack   (ack),
        .rd    (rd),
        .miss  (miss)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: at %0t ns, %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        checks_at_start = check_count;
    endtask

    task automatic finish_test();
        bit ok;
        ok = (error_count == errors_at_start);
        tests_run++;
        if (!ok) tests_failed++;
        $display("test %-22s %s (%0d checks)", test_name, ok ? "passed" : "FAILED",
                 check_count - checks_at_start);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          line_no;
        int          m;
        string       line;
        string       tok;
        string       name;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] e;
        line_no = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                n = $sscanf(line, "%s", tok);
                if (n < 1 || tok.substr(0, 0) == "#") continue;   // blank or comment
                if (tok == "test") begin
                    n = $sscanf(line, "%s %s", tok, name);
                    op_q.push_back("T");
                    name_q.push_back(name);
                    addr_q.push_back('0);
                    wd_q.push_back('0);
                    exp_rd_q.push_back('0);
                    exp_miss_q.push_back(1'b0);
                end else if ((tok == "R" || tok == "W") &&
                             $sscanf(line, "%s %h %h %h %d", tok, a, w, e, m) == 5) begin
                    op_q.push_back(tok == "W" ? "W" : "R");
                    name_q.push_back("");
                    addr_q.push_back(a);
                    wd_q.push_back(w);
                    exp_rd_q.push_back(e);
                    exp_miss_q.push_back(m != 0);
                    access_total++;
                end else begin
                    error_count++;
                    $display("stimulus file line %0d could not be parsed", line_no);
                end
            end
            $fclose(fd);
        end
    endtask

    // one full four-phase handshake with outputs sampled mid-cycle
    task automatic run_access(input bit op_we, input logic [31:0] a, input logic [31:0] w,
                              output logic [31:0] rd_out, output logic miss_out);
        @(posedge clk);
        req  <= 1'b1;
        we   <= op_we;
        addr <= a;
        wd   <= w;
        do @(negedge clk); while (ack !== 1'b1);
        rd_out   = rd;
        miss_out = miss;
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack !== 1'b0);
    endtask

    task automatic model_access(input bit is_write, input logic [31:0] a,
                                input logic [31:0] w, output logic [31:0] rd_exp,
                                output bit miss_exp);
        int          set;
        int          way;
        logic [20:0] tag;
        set = a[10:2];
        tag = a[31:11];
        way = -1;
        for (int k = 0; k < 2; k++) begin
            if (model_valid[set][k] && model_tag[set][k] == tag) way = k;
        end
        miss_exp = (way < 0);
        if (miss_exp) begin
            if (!model_valid[set][0]) way = 0;
            else if (!model_valid[set][1]) way = 1;
            else way = model_lru[set];
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = tag;
        end
        model_lru[set] = (way == 0);   // other way goes next
        rd_exp = model_mem.exists(a) ? model_mem[a] : '0;
        if (is_write) model_mem[a] = w;
    endtask

    initial begin
        req  = 1'b0;
        we   = 1'b0;
        addr = '0;
        wd   = '0;
        load_stimulus();
        access_total += N_RANDOM;

        wait (rst_n === 1'b1);
        @(negedge clk);
        start_test("reset");
        check_value("ack after reset", {31'b0, ack}, 32'd0);
        finish_test();

        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "T") begin
                if (test_open) finish_test();
                start_test(name_q[i]);
                test_open = 1'b1;
            end else begin
                run_access(op_q[i] == "W", addr_q[i], wd_q[i], got_rd, got_miss);
                check_value($sformatf("miss at %h", addr_q[i]), {31'b0, got_miss},
                            {31'b0, exp_miss_q[i]});
                if (op_q[i] == "R") begin
                    check_value($sformatf("read data at %h", addr_q[i]), got_rd, exp_rd_q[i]);
                end
            end
        end
        if (test_open) finish_test();

        // six tags over four sets keep both ways busy
        start_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            r      = lcg_next();
            r_we   = r[31];
            r_addr = (((r >> 24) % 6) << 11) | ((16 + ((r >> 20) & 3)) << 2);
            r_wd   = lcg_next();
            run_access(r_we, r_addr, r_wd, got_rd, got_miss);
            model_access(r_we, r_addr, r_wd, exp_rd, exp_miss);
            check_value($sformatf("random miss at %h", r_addr), {31'b0, got_miss},
                        {31'b0, exp_miss});
            if (!r_we) check_value($sformatf("random read at %h", r_addr), got_rd, exp_rd);
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (access_total > 0);
        #(access_total * ACCESS_NS + MARGIN_NS);
        $display("timeout: the cache stopped answering before all accesses were done");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // reset held low over two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- hw/two_way_cache_top.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module two_way_cache_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // request
    input  logic                 req,
    input  logic                 we,
    input  cache_pkg::ram_addr_t addr,
    input  cache_pkg::data_t     wd,

    // response
    output logic                 ack,
    output cache_pkg::data_t     rd,
    output logic                 miss
);

    set_if set_bus ();
    mem_if mem_bus ();

    cache_sequencer u_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .we      (we),
        .addr    (addr),
        .wd      (wd),
        .ack     (ack),
        .rd      (rd),
        .miss    (miss),
        .set_bus (set_bus),
        .mem_bus (mem_bus)
    );

    cache_set_array u_sets (
        .clk     (clk),
        .rst_n   (rst_n),
        .set_bus (set_bus)
    );

    // only the low 64 KiB is backed
    backing_ram #(
        .WORD_BITS (`RAM_WORD_BITS)
    ) u_ram (
        .clk     (clk),
        .mem_bus (mem_bus)
    );

endmodule

//--- hw/cache_sequencer.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,

    // requester, four-phase handshake
    input  logic                 req,
    input  logic                 we,
    input  cache_pkg::ram_addr_t addr,
    input  cache_pkg::data_t     wd,
    output logic                 ack,
    output cache_pkg::data_t     rd,
    output logic                 miss,

    set_if.ctrl                  set_bus,
    mem_if.ctrl                  mem_bus
);
    import cache_pkg::*;

    seq_state_t state;
    seq_state_t next_state;

    // latched request
    logic      req_we;
    ram_addr_t req_addr;
    data_t     req_wd;
    tag_t      req_tag;
    set_idx_t  req_set;

    // controller results
    logic      ctl_en;
    logic      ctl_after_miss;
    logic      ctl_miss;
    data_t     ctl_data;
    set_line_t ctl_set;
    logic      ctl_we_cache;
    data_t     ctl_evict_word;
    ram_addr_t ctl_evict_addr;
    logic      ctl_we_ram;

    assign req_tag = req_addr[`RAM_ADDR_WIDTH-1 -: `CACHE_TAG_SIZE];
    assign req_set = req_addr[`CACHE_SET_BITS+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (req) next_state = LOOKUP;
            LOOKUP:  next_state = EVAL;
            EVAL:    next_state = ctl_miss ? FILL : DONE;
            FILL:    next_state = DONE;
            DONE:    if (!req) next_state = IDLE;   // stall here until req drops
            default: next_state = IDLE;
        endcase
    end

    // capture the request, inputs are stable while req is high
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_we   <= we;
            req_addr <= addr;
            req_wd   <= wd;
        end
    end

    assign ctl_en         = (state == EVAL) || (state == FILL);
    assign ctl_after_miss = (state == FILL);

    two_way_cache_controller u_ctrl (
        .en               (ctl_en),
        .we               (req_we),
        .wd               (req_wd),
        .target_set       (req_set),
        .target_tag       (req_tag),
        .set_data         (set_bus.rd_set),
        .after_miss       (ctl_after_miss),
        .rd_from_ram      (mem_bus.rd_data),
        .cache_miss       (ctl_miss),
        .data_out         (ctl_data),
        .updated_set_data (ctl_set),
        .we_to_cache      (ctl_we_cache),
        .evicted_word     (ctl_evict_word),
        .evicted_ram_addr (ctl_evict_addr),
        .we_to_ram        (ctl_we_ram)
    );

    // set array, read in LOOKUP and written back in EVAL or FILL
    assign set_bus.rd_idx = req_set;
    assign set_bus.wr_en  = ctl_we_cache;
    assign set_bus.wr_idx = req_set;
    assign set_bus.wr_set = ctl_set;

    // refill read and victim write go out together in EVAL
    assign mem_bus.rd_en   = ctl_miss;
    assign mem_bus.rd_addr = req_addr;
    assign mem_bus.wr_en   = ctl_we_ram;
    assign mem_bus.wr_addr = ctl_evict_addr;
    assign mem_bus.wr_data = ctl_evict_word;

    // response, held steady through DONE
    always_ff @(posedge clk) begin
        if ((state == EVAL && !ctl_miss) || state == FILL) begin
            rd <= ctl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss <= 1'b0;
        end else if (state == EVAL) begin
            miss <= ctl_miss;
        end
    end

    assign ack = (state == DONE);

endmodule

//--- hw/two_way_cache_controller.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module two_way_cache_controller (
    // request side
    input  logic                 en,          // only touch the set while enabled
    input  logic                 we,
    input  cache_pkg::data_t     wd,
    input  cache_pkg::set_idx_t  target_set,
    input  cache_pkg::tag_t      target_tag,

    input  cache_pkg::set_line_t set_data,    // set as read from the array

    // refill from memory
    input  logic                 after_miss,
    input  cache_pkg::data_t     rd_from_ram,
    output logic                 cache_miss,
    output cache_pkg::data_t     data_out,

    // set write-back
    output cache_pkg::set_line_t updated_set_data,
    output logic                 we_to_cache,

    // dirty eviction to memory
    output cache_pkg::data_t     evicted_word,
    output cache_pkg::ram_addr_t evicted_ram_addr,
    output logic                 we_to_ram
);
    import cache_pkg::*;

    localparam int WAY_BITS = `CACHE_DATA_WIDTH + `CACHE_TAG_SIZE + 2;

    logic       lru_bit;      // way to replace next
    logic [1:0] v_bits;
    logic [1:0] dirty_bits;
    tag_t       tags [2];
    data_t      words [2];
    logic [1:0] hits;

    logic       evict_way;
    logic       use_way;      // way holding the target once the access completes

    logic       new_lru_bit;
    logic [1:0] new_v_bits;
    logic [1:0] new_dirty_bits;
    tag_t       new_tags [2];
    data_t      new_words [2];

    // unpack both ways and compare tags
    always_comb begin
        lru_bit = set_data[`CACHE_SET_SIZE-1];
        for (int w = 0; w < 2; w++) begin
            words[w]      = set_data[w*WAY_BITS +: `CACHE_DATA_WIDTH];
            tags[w]       = set_data[w*WAY_BITS + `CACHE_DATA_WIDTH +: `CACHE_TAG_SIZE];
            dirty_bits[w] = set_data[w*WAY_BITS + WAY_BITS - 2];
            v_bits[w]     = set_data[w*WAY_BITS + WAY_BITS - 1];
            hits[w]       = v_bits[w] && (tags[w] == target_tag);
        end
    end

    // invalid way first, way 1 before way 0, else the lru way
    assign evict_way = !v_bits[1] ? 1'b1 : (!v_bits[0] ? 1'b0 : lru_bit);

    always_comb begin
        cache_miss       = 1'b0;
        we_to_ram        = 1'b0;
        evicted_word     = '0;
        evicted_ram_addr = '0;
        data_out         = '0;
        use_way          = 1'b0;

        new_lru_bit    = lru_bit;
        new_v_bits     = v_bits;
        new_dirty_bits = dirty_bits;
        new_tags       = tags;
        new_words      = words;

        if (en) begin
            if (|hits) begin
                use_way  = hits[1];
                data_out = words[hits[1]];
            end else if (!after_miss) begin
                // first pass, request the refill and push out a dirty victim
                cache_miss = 1'b1;
                if (v_bits[evict_way] && dirty_bits[evict_way]) begin
                    we_to_ram        = 1'b1;
                    evicted_word     = words[evict_way];
                    evicted_ram_addr = {tags[evict_way], target_set, 2'b00};
                end
            end else begin
                new_words[evict_way]      = rd_from_ram;   // installed clean
                new_tags[evict_way]       = target_tag;
                new_v_bits[evict_way]     = 1'b1;
                new_dirty_bits[evict_way] = 1'b0;
                use_way                   = evict_way;
                data_out                  = rd_from_ram;
            end

            // set is left alone while the refill is pending
            if (!cache_miss) begin
                new_lru_bit = ~use_way;
                if (we) begin
                    new_words[use_way]      = wd;
                    new_dirty_bits[use_way] = 1'b1;
                end
            end
        end
    end

    // repack in the same layout
    always_comb begin
        updated_set_data[`CACHE_SET_SIZE-1] = new_lru_bit;
        for (int w = 0; w < 2; w++) begin
            updated_set_data[w*WAY_BITS +: WAY_BITS] =
                {new_v_bits[w], new_dirty_bits[w], new_tags[w], new_words[w]};
        end
    end

    assign we_to_cache = en && (updated_set_data != set_data);

endmodule

//--- hw/backing_ram.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module backing_ram #(
    parameter int WORD_BITS = `RAM_WORD_BITS
) (
    input logic clk,
    mem_if.mem  mem_bus
);
    import cache_pkg::*;

    localparam int DEPTH = 2 ** WORD_BITS;

    data_t mem_words [DEPTH];

    // memory starts out all zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_words[i] = '0;
        end
    end

    // word index is byte address [WORD_BITS+1:2]
    always_ff @(posedge clk) begin
        if (mem_bus.wr_en) begin
            mem_words[mem_bus.wr_addr[WORD_BITS+1:2]] <= mem_bus.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_bus.rd_en) begin
            mem_bus.rd_data <= mem_words[mem_bus.rd_addr[WORD_BITS+1:2]];
        end
    end

endmodule

//--- hw/cache_set_array.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_set_array (
    input logic clk,
    input logic rst_n,
    set_if.store set_bus
);
    import cache_pkg::*;

    set_line_t set_mem [`CACHE_SETS];

    // write port, reset invalidates every way and clears the lru bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                set_mem[i] <= '0;
            end
        end else if (set_bus.wr_en) begin
            set_mem[set_bus.wr_idx] <= set_bus.wr_set;
        end
    end

    // registered read, returns the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        set_bus.rd_set <= set_mem[set_bus.rd_idx];
    end

endmodule

//--- hw/mem_if.sv
`timescale 1ns/100ps

interface mem_if;
    import cache_pkg::*;

    logic      rd_en;
    ram_addr_t rd_addr;
    data_t     rd_data;   // one cycle after rd_en

    logic      wr_en;
    ram_addr_t wr_addr;
    data_t     wr_data;

    modport ctrl (
        output rd_en, rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data
    );

    modport mem (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );

endinterface

//--- hw/set_if.sv
`timescale 1ns/100ps

interface set_if;
    import cache_pkg::*;

    // read side
    set_idx_t  rd_idx;
    set_line_t rd_set;   // valid the cycle after rd_idx

    // write side
    logic      wr_en;
    set_idx_t  wr_idx;
    set_line_t wr_set;

    modport ctrl (
        output rd_idx, wr_en, wr_idx, wr_set,
        input  rd_set
    );

    modport store (
        input  rd_idx, wr_en, wr_idx, wr_set,
        output rd_set
    );

endinterface

//--- hw/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_DATA_WIDTH-1:0] data_t;
    typedef logic [`CACHE_TAG_SIZE-1:0]   tag_t;
    typedef logic [`CACHE_SET_BITS-1:0]   set_idx_t;
    typedef logic [`RAM_ADDR_WIDTH-1:0]   ram_addr_t;  // {tag, set, 2'b00}

    // lru, way 1 {v, d, tag, word}, way 0 {v, d, tag, word}
    typedef logic [`CACHE_SET_SIZE-1:0]   set_line_t;

    // request sequencer
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,   // set read issued
        EVAL,     // hit check, write-back and refill request
        FILL,     // refill word merged
        DONE      // ack held until req drops
    } seq_state_t;

endpackage

//--- hw/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// data path
`define CACHE_DATA_WIDTH 32
`define CACHE_TAG_SIZE   21

// set organisation
`define CACHE_SET_BITS   9
`define CACHE_SETS       512
`define CACHE_SET_SIZE   111   // lru + 2 x (valid, dirty, tag, word)

// backing memory
`define RAM_ADDR_WIDTH   32    // byte address
`define RAM_WORD_BITS    14    // 16k words, low 64 KiB

`endif
